//--- src.f
+incdir+dv
rtl/cart_pkg.sv
rtl/map_if.sv
rtl/address_map.sv
rtl/periph_decode.sv
rtl/snescmd_buf.sv
rtl/cart_bus_ctrl.sv
rtl/snes_cart_map.sv
dv/tb_snes_cart_map.sv

//--- run.sh
#!/bin/sh
# compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f src.f --top-module tb_snes_cart_map -o sim_tb
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit 1
fi

if echo "$out" | grep -q "Test completed successfully"; then
  exit 0
fi
exit 1

//--- dv/cart_ref.svh
`ifndef CART_REF_SVH
`define CART_REF_SVH

// DSP-x window per mapper, gated by the feature bit
function automatic logic ref_dspx(logic [23:0] a, cart_pkg::mapper_e m,
                                  logic [23:0] rmask, logic [7:0] f);
  logic [7:0]  bank;
  logic [15:0] off;
  bank = a[23:16] & 8'h7F;
  off  = a[15:0];
  if (!f[cart_pkg::FEAT_DSPX]) return 1'b0;
  if (m == cart_pkg::MAP_LOROM) begin
    // large images move the window to banks 60-6f, lower half
    if (rmask[20]) return (bank >= 8'h60) && (bank <= 8'h6F) && (off < 16'h8000);
    return (bank >= 8'h30) && (bank <= 8'h3F) && (off >= 16'h8000);
  end
  if (m == cart_pkg::MAP_HIROM) begin
    return (bank <= 8'h0F) && (off >= 16'h6000) && (off <= 16'h7FFF);
  end
  return 1'b0;
endfunction

// enables as {msu, srtc, dspx, a0, 213f, cmd read}
function automatic logic [5:0] ref_enables(logic [23:0] a, logic [7:0] pa,
                                           cart_pkg::mapper_e m, logic [23:0] rmask,
                                           logic [7:0] f);
  logic low;
  logic msu;
  logic srtc;
  logic a0;
  low  = !a[22];
  msu  = f[cart_pkg::FEAT_MSU1] && low && (a[15:0] >= 16'h2000) && (a[15:0] <= 16'h2007);
  srtc = f[cart_pkg::FEAT_SRTC] && low && (a[15:0] >= 16'h2800) && (a[15:0] <= 16'h2801);
  case (m)
    cart_pkg::MAP_LOROM: a0 = a[14];
    cart_pkg::MAP_HIROM: a0 = a[12];
    default:             a0 = 1'b1;
  endcase
  return {msu, srtc, ref_dspx(a, m, rmask, f), a0,
          f[cart_pkg::FEAT_213F] && low && (pa == 8'h3F), low && (pa >= 8'hF0)};
endfunction

// save RAM window, only present with mask bit 0 set
function automatic logic ref_saveram(logic [23:0] a, cart_pkg::mapper_e m,
                                     logic [23:0] smask);
  logic [7:0] bank;
  bank = a[23:16] & 8'h7F;
  if (!smask[0]) return 1'b0;
  if (m == cart_pkg::MAP_LOROM) return (bank >= 8'h70) && (bank <= 8'h7D) && !a[15];
  return !a[22] && a[21] && (a[15:13] == 3'b011);
endfunction

function automatic cart_pkg::region_e ref_region(logic [23:0] a, cart_pkg::mapper_e m,
                                                 logic [7:0] f, logic [23:0] rmask,
                                                 logic [23:0] smask);
  logic [5:0] en;
  en = ref_enables(a, 8'h00, m, rmask, f);
  if (a[23:4] == cart_pkg::CMD_WINDOW) return cart_pkg::REG_CMD;
  if (en[5] || en[4] || en[3]) return cart_pkg::REG_PERIPH;
  if (ref_saveram(a, m, smask)) return cart_pkg::REG_SAVERAM;
  if (a[22] || a[15]) return cart_pkg::REG_ROM;
  return cart_pkg::REG_NONE;
endfunction

// SRAM address of a save RAM or ROM access
function automatic logic [23:0] ref_xlat(logic [23:0] a, cart_pkg::mapper_e m, logic sv,
                                         logic [23:0] rmask, logic [23:0] smask);
  logic [14:0] moff;
  moff = a[14:0] - 15'h6000;
  if (sv && (m == cart_pkg::MAP_MENU)) return cart_pkg::MENU_SAVE_BASE + ({9'h0, moff} & smask);
  if (sv) return cart_pkg::SAVERAM_BASE + ({4'h0, a[20:16], a[14:0]} & smask);
  case (m)
    cart_pkg::MAP_LOROM:   return {2'b00, a[22:16], a[14:0]} & rmask;
    cart_pkg::MAP_EXHIROM: return {1'b0, ~a[23], a[21:0]} & rmask;
    cart_pkg::MAP_MENU:    return cart_pkg::MENU_ROM_BASE + ({1'b0, a[22:0]} & rmask);
    default:               return {1'b0, a[22:0]} & rmask;
  endcase
endfunction

`endif

//--- dv/tb_snes_cart_map.sv
module tb_snes_cart_map;

  timeunit 1ns;
  timeprecision 100ps;

  `include "cart_ref.svh"

  logic              clk;
  logic              arst_n;
  logic              snes_req;
  logic [23:0]       snes_addr;
  logic [7:0]        snes_pa;
  logic              snes_we;
  logic [7:0]        snes_wdata;
  logic              snes_ack;
  logic [7:0]        snes_rdata;
  cart_pkg::mapper_e mapper;
  logic [7:0]        featurebits;
  logic [23:0]       rom_mask;
  logic [23:0]       saveram_mask;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [23:0]       wb_adr;
  logic [7:0]        wb_dat_o;
  logic [7:0]        wb_dat_i;
  logic              wb_ack;
  logic              msu_en;
  logic              srtc_en;
  logic              dspx_en;
  logic              dspx_a0;
  logic              r213f_en;
  logic              snescmd_rd_en;
  logic [3:0]        mcu_cmd_idx;
  logic [7:0]        mcu_cmd_data;

  integer      seed = 27836;
  int          edge_cnt;
  // expectations for the access in flight
  logic        exp_mem;
  logic        exp_we;
  logic [23:0] exp_adr;
  logic [7:0]  exp_rdata;
  logic [5:0]  exp_en;
  logic        cur_we;
  // slave model state
  logic [7:0]  sram [int];
  logic        saw_cyc;
  logic        in_cycle;
  logic [23:0] cap_adr;
  logic        cap_we;
  int          wait_left;
  // what the SRAM and command buffer should hold
  logic [7:0]  shadow [int];
  logic [7:0]  cmd_shadow [16];

  logic [23:0] dirs [12] = '{24'h008000, 24'h400000, 24'h206000, 24'h700000,
                             24'h002000, 24'h002800, 24'h308000, 24'h600000,
                             24'h006000, 24'hCCCCC0, 24'h001000, 24'hC00000};

  snes_cart_map #(
    .CMD_DEPTH (16)
  ) i_snes_cart_map (
    .clk           (clk),
    .arst_n        (arst_n),
    .snes_req      (snes_req),
    .snes_addr     (snes_addr),
    .snes_pa       (snes_pa),
    .snes_we       (snes_we),
    .snes_wdata    (snes_wdata),
    .snes_ack      (snes_ack),
    .snes_rdata    (snes_rdata),
    .mapper        (mapper),
    .featurebits   (featurebits),
    .rom_mask      (rom_mask),
    .saveram_mask  (saveram_mask),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_o      (wb_dat_o),
    .wb_dat_i      (wb_dat_i),
    .wb_ack        (wb_ack),
    .msu_en        (msu_en),
    .srtc_en       (srtc_en),
    .dspx_en       (dspx_en),
    .dspx_a0       (dspx_a0),
    .r213f_en      (r213f_en),
    .snescmd_rd_en (snescmd_rd_en),
    .mcu_cmd_idx   (mcu_cmd_idx),
    .mcu_cmd_data  (mcu_cmd_data)
  );

  always #5 clk = ~clk;

  // initial memory contents, every address bit matters
  function automatic logic [7:0] fill_byte(logic [23:0] a);
    return a[7:0] ^ {a[11:8], a[15:12]} ^ (a[23:16] * 8'd3);
  endfunction

  task automatic fail_check(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("Test failed");
    $fatal(1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Wishbone slave model
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (wb_ack) begin
      wb_ack = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!in_cycle) begin
        in_cycle  = 1'b1;
        saw_cyc   = 1'b1;
        cap_adr   = wb_adr;
        cap_we    = wb_we;
        wait_left = {$random(seed)} % 4;
      end
      if (wait_left == 0) begin
        if (wb_we) begin
          sram[int'(wb_adr)] = wb_dat_o;
        end else begin
          if (!sram.exists(int'(wb_adr))) sram[int'(wb_adr)] = fill_byte(wb_adr);
          wb_dat_i = sram[int'(wb_adr)];
        end
        wb_ack   = 1'b1;
        in_cycle = 1'b0;
      end else begin
        wait_left--;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checker
  //////////////////////////////////////////////////////////////////////

  // edges since the request edge
  always @(posedge clk) begin
    if (snes_req) edge_cnt <= 0;
    else          edge_cnt <= edge_cnt + 1;
  end

  always @(negedge clk) begin
    if (arst_n && snes_ack) begin
      if (exp_mem) begin
        assert (saw_cyc) else fail_check("memory access without a Wishbone cycle");
        assert (cap_adr == exp_adr)
          else fail_check($sformatf("wb_adr %h, expected %h", cap_adr, exp_adr));
        assert (cap_we == exp_we)
          else fail_check($sformatf("wb_we %b, expected %b", cap_we, exp_we));
      end else begin
        assert (!saw_cyc) else fail_check("Wishbone cycle for a local access");
        // ack two cycles after the request
        assert (edge_cnt == 1)
          else fail_check($sformatf("ack after %0d edges, expected 1", edge_cnt));
      end
      if (!cur_we) begin
        assert (snes_rdata == exp_rdata)
          else fail_check($sformatf("rdata %h, expected %h", snes_rdata, exp_rdata));
      end
      assert ({msu_en, srtc_en, dspx_en, dspx_a0, r213f_en, snescmd_rd_en} == exp_en)
        else fail_check($sformatf("enables %b, expected %b",
                        {msu_en, srtc_en, dspx_en, dspx_a0, r213f_en, snescmd_rd_en},
                        exp_en));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  // one console access, called on a falling edge
  task automatic do_access(input logic [23:0] a, input logic [7:0] p,
                           input logic w, input logic [7:0] d);
    cart_pkg::region_e reg_x;
    logic              sv;
    int                n;
    reg_x   = ref_region(a, mapper, featurebits, rom_mask, saveram_mask);
    sv      = (reg_x == cart_pkg::REG_SAVERAM);
    exp_mem = sv || ((reg_x == cart_pkg::REG_ROM) && !w);
    exp_we  = w && sv;
    exp_adr = ref_xlat(a, mapper, sv, rom_mask, saveram_mask);
    exp_en  = ref_enables(a, p, mapper, rom_mask, featurebits);
    cur_we  = w;
    if (!exp_mem) exp_rdata = cart_pkg::OPEN_BUS;
    else if (shadow.exists(int'(exp_adr))) exp_rdata = shadow[int'(exp_adr)];
    else exp_rdata = fill_byte(exp_adr);
    if (exp_we) shadow[int'(exp_adr)] = d;
    if (w && (reg_x == cart_pkg::REG_CMD)) cmd_shadow[a[3:0]] = d;
    saw_cyc    = 1'b0;
    snes_addr  = a;
    snes_pa    = p;
    snes_we    = w;
    snes_wdata = d;
    snes_req   = 1'b1;
    @(negedge clk);
    snes_req = 1'b0;
    n = 0;
    while (!snes_ack) begin
      if (n == 50) begin
        $display("no acknowledge from the DUT within 50 cycles at %0t ns", $time);
        $display("Test failed");
        $fatal(1);
      end
      @(negedge clk);
      n++;
    end
    // controller returns to idle on the next edge
    @(negedge clk);
  endtask

  // MCU side readback of every command slot
  task automatic check_cmd_buf();
    for (int i = 0; i < 16; i++) begin
      mcu_cmd_idx = i[3:0];
      #1;
      assert (mcu_cmd_data == cmd_shadow[i])
        else fail_check($sformatf("cmd slot %0d holds %h, expected %h",
                        i, mcu_cmd_data, cmd_shadow[i]));
    end
  endtask

  initial begin
    cart_pkg::mapper_e maps [4];
    logic [31:0]       r;
    logic [23:0]       a;
    logic [7:0]        p;
    logic [7:0]        d;
    maps = '{cart_pkg::MAP_HIROM, cart_pkg::MAP_LOROM,
             cart_pkg::MAP_EXHIROM, cart_pkg::MAP_MENU};
    clk          = 1'b0;
    arst_n       = 1'b0;
    snes_req     = 1'b0;
    snes_addr    = '0;
    snes_pa      = '0;
    snes_we      = 1'b0;
    snes_wdata   = '0;
    mapper       = cart_pkg::MAP_HIROM;
    featurebits  = '0;
    rom_mask     = 24'h3FFFFF;
    saveram_mask = 24'h001FFF;
    wb_dat_i     = '0;
    wb_ack       = 1'b0;
    mcu_cmd_idx  = '0;
    in_cycle     = 1'b0;
    saw_cyc      = 1'b0;
    for (int i = 0; i < 16; i++) cmd_shadow[i] = 8'h00;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    // quiet state out of reset
    assert (!wb_cyc && !wb_stb && !snes_ack) else fail_check("bus active after reset");
    assert ({msu_en, srtc_en, dspx_en, dspx_a0, r213f_en, snescmd_rd_en} == 6'b000100)
      else fail_check("enables not at reset values");

    for (int m = 0; m < 4; m++) begin
      mapper = maps[m];
      for (int s = 0; s < 2; s++) begin
        // bit 0 clear removes save RAM
        saveram_mask = s ? 24'h001FFF : 24'h001FFE;
        for (int k = 0; k < 40; k++) begin
          r           = $random(seed);
          featurebits = 8'($random(seed));
          rom_mask    = r[12] ? 24'h3FFFFF : 24'h0FFFFF;
          if (r[3]) a = 24'($random(seed));
          else a = dirs[{$random(seed)} % 12] + {20'h0, r[7:4]};
          p = (r[9:8] == 2'b00) ? 8'h3F : 8'($random(seed));
          do_access(a, p, r[10] & r[11], 8'($random(seed)));
        end
        // save RAM write then read back
        for (int j = 0; j < 4; j++) begin
          r = $random(seed);
          if (mapper == cart_pkg::MAP_LOROM) a = {8'h70, 1'b0, r[14:0]};
          else a = {3'b001, r[20:16], 3'b011, r[12:0]};
          d = 8'($random(seed));
          do_access(a, 8'h00, 1'b1, d);
          do_access(a, 8'h00, 1'b0, 8'h00);
        end
      end
    end

    // command window writes
    for (int i = 0; i < 16; i++) begin
      do_access({cart_pkg::CMD_WINDOW, i[3:0]}, 8'h00, 1'b1, 8'($random(seed)));
    end
    check_cmd_buf();

    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- rtl/snes_cart_map.sv
module snes_cart_map #(
  parameter int CMD_DEPTH = 16
) (
  input  logic              clk,
  input  logic              arst_n,
  // console bus
  input  logic              snes_req,
  input  logic [23:0]       snes_addr,
  input  logic [7:0]        snes_pa,
  input  logic              snes_we,
  input  logic [7:0]        snes_wdata,
  output logic              snes_ack,
  output logic [7:0]        snes_rdata,
  // static configuration from the MCU
  input  cart_pkg::mapper_e mapper,
  input  logic [7:0]        featurebits,
  input  logic [23:0]       rom_mask,
  input  logic [23:0]       saveram_mask,
  // external SRAM, Wishbone master
  output logic              wb_cyc,
  output logic              wb_stb,
  output logic              wb_we,
  output logic [23:0]       wb_adr,
  output logic [7:0]        wb_dat_o,
  input  logic [7:0]        wb_dat_i,
  input  logic              wb_ack,
  // coprocessor and peripheral enables
  output logic              msu_en,
  output logic              srtc_en,
  output logic              dspx_en,
  output logic              dspx_a0,
  output logic              r213f_en,
  output logic              snescmd_rd_en,
  // MCU command readback
  input  logic [3:0]        mcu_cmd_idx,
  output logic [7:0]        mcu_cmd_data
);

  logic periph_hit;
  logic cmd_wr;

  map_if map_bus ();

  //////////////////////////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////////////////////////

  address_map i_address_map (
    .clk          (clk),
    .arst_n       (arst_n),
    .req          (snes_req),
    .addr         (snes_addr),
    .mapper       (mapper),
    .featurebits  (featurebits),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask),
    .periph_hit   (periph_hit),
    .map          (map_bus.mapper)
  );

  periph_decode i_periph_decode (
    .clk           (clk),
    .arst_n        (arst_n),
    .req           (snes_req),
    .addr          (snes_addr),
    .pa            (snes_pa),
    .featurebits   (featurebits),
    .mapper        (mapper),
    .rom_mask      (rom_mask),
    .dspx_hit      (map_bus.dspx_hit),
    .msu_en        (msu_en),
    .srtc_en       (srtc_en),
    .dspx_en       (dspx_en),
    .dspx_a0       (dspx_a0),
    .r213f_en      (r213f_en),
    .snescmd_rd_en (snescmd_rd_en),
    .periph_hit    (periph_hit)
  );

  //////////////////////////////////////////////////////////////////////
  // command buffer and bus control
  //////////////////////////////////////////////////////////////////////

  // index from the decode result, byte from the latched write data
  snescmd_buf #(
    .CMD_DEPTH (CMD_DEPTH)
  ) i_snescmd_buf (
    .clk     (clk),
    .arst_n  (arst_n),
    .wr      (cmd_wr),
    .wr_idx  (map_bus.sram_addr[3:0]),
    .wr_data (wb_dat_o),
    .rd_idx  (mcu_cmd_idx),
    .rd_data (mcu_cmd_data)
  );

  cart_bus_ctrl i_cart_bus_ctrl (
    .clk        (clk),
    .arst_n     (arst_n),
    .req        (snes_req),
    .we         (snes_we),
    .wdata      (snes_wdata),
    .map        (map_bus.ctrl),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_o   (wb_dat_o),
    .wb_dat_i   (wb_dat_i),
    .wb_ack     (wb_ack),
    .cmd_wr     (cmd_wr),
    .snes_ack   (snes_ack),
    .snes_rdata (snes_rdata)
  );

endmodule

//--- rtl/cart_bus_ctrl.sv
module cart_bus_ctrl (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        req,
  input  logic        we,
  input  logic [7:0]  wdata,
  map_if.ctrl         map,
  output logic        wb_cyc,
  output logic        wb_stb,
  output logic        wb_we,
  output logic [23:0] wb_adr,
  output logic [7:0]  wb_dat_o,
  input  logic [7:0]  wb_dat_i,
  input  logic        wb_ack,
  output logic        cmd_wr,
  output logic        snes_ack,
  output logic [7:0]  snes_rdata
);

  cart_pkg::ctrl_state_e state;
  logic                  we_q;
  logic                  mem_go;

  // memory cycle for save RAM, or ROM reads only
  assign mem_go = (map.region == cart_pkg::REG_SAVERAM)
               || ((map.region == cart_pkg::REG_ROM) && !we_q);

  // command byte goes in while the decode is fresh
  assign cmd_wr = (state == cart_pkg::ST_DECODE) && map.valid && we_q
               && (map.region == cart_pkg::REG_CMD);

  assign snes_ack = (state == cart_pkg::ST_ACK);

  //////////////////////////////////////////////////////////////////////
  // control FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state  <= cart_pkg::ST_IDLE;
      we_q   <= 1'b0;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
    end else begin
      case (state)
        cart_pkg::ST_IDLE: begin
          if (req) begin
            state <= cart_pkg::ST_DECODE;
            we_q  <= we;
          end
        end
        cart_pkg::ST_DECODE: begin
          if (map.valid) begin
            if (mem_go) begin
              // cyc and stb rise together
              state  <= cart_pkg::ST_BUS;
              wb_cyc <= 1'b1;
              wb_stb <= 1'b1;
              wb_we  <= we_q & map.writable;
            end else begin
              // dropped or local access, fixed latency
              state <= cart_pkg::ST_ACK;
            end
          end
        end
        cart_pkg::ST_BUS: begin
          // slave stall just holds us here
          if (wb_ack) begin
            state  <= cart_pkg::ST_ACK;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
          end
        end
        cart_pkg::ST_ACK: state <= cart_pkg::ST_IDLE;
        default:          state <= cart_pkg::ST_IDLE;
      endcase
    end
  end

  // payload path
  always_ff @(posedge clk) begin
    if ((state == cart_pkg::ST_IDLE) && req) begin
      wb_dat_o <= wdata;
    end
    if (state == cart_pkg::ST_DECODE) begin
      wb_adr     <= map.sram_addr;
      snes_rdata <= cart_pkg::OPEN_BUS;
    end else if ((state == cart_pkg::ST_BUS) && wb_ack && !wb_we) begin
      snes_rdata <= wb_dat_i;
    end
  end

  a_stb_in_cycle: assert property (
    @(posedge clk) disable iff (!arst_n)
    wb_stb |-> wb_cyc && (state == cart_pkg::ST_BUS)
  );

  a_we_only_saveram: assert property (
    @(posedge clk) disable iff (!arst_n)
    wb_we |-> map.region == cart_pkg::REG_SAVERAM
  );

  // console holds off until the previous ack
  a_req_when_idle: assert property (
    @(posedge clk) disable iff (!arst_n)
    req |-> state == cart_pkg::ST_IDLE
  );

endmodule

//--- rtl/snescmd_buf.sv
module snescmd_buf #(
  parameter int CMD_DEPTH = 16
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       wr,
  input  logic [3:0] wr_idx,
  input  logic [7:0] wr_data,
  input  logic [3:0] rd_idx,
  output logic [7:0] rd_data
);

  logic [7:0] mem [CMD_DEPTH];

  //////////////////////////////////////////////////////////////////////
  // console write side
  //////////////////////////////////////////////////////////////////////

  // buffer starts clean so the MCU never sees stale commands
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < CMD_DEPTH; i++) begin
        mem[i] <= 8'h00;
      end
    end else if (wr && (int'(wr_idx) < CMD_DEPTH)) begin
      mem[wr_idx] <= wr_data;
    end
  end

  // MCU read, unbacked slots float to open bus
  assign rd_data = (int'(rd_idx) < CMD_DEPTH) ? mem[rd_idx] : cart_pkg::OPEN_BUS;

  a_wr_idx_in_range: assert property (
    @(posedge clk) disable iff (!arst_n)
    wr |-> int'(wr_idx) < CMD_DEPTH
  );

endmodule

//--- rtl/periph_decode.sv
module periph_decode (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              req,
  input  logic [23:0]       addr,
  input  logic [7:0]        pa,
  input  logic [7:0]        featurebits,
  input  cart_pkg::mapper_e mapper,
  input  logic [23:0]       rom_mask,
  input  logic              dspx_hit,
  output logic              msu_en,
  output logic              srtc_en,
  output logic              dspx_en,
  output logic              dspx_a0,
  output logic              r213f_en,
  output logic              snescmd_rd_en,
  output logic              periph_hit
);

  logic msu_d;
  logic srtc_d;
  logic r213f_d;
  logic cmd_rd_d;
  logic a0_d;

  // msu1 registers 2000-2007
  assign msu_d = featurebits[cart_pkg::FEAT_MSU1] & ~addr[22]
               & (addr[15:3] == 13'h0400);
  // s-rtc data and control at 2800/2801
  assign srtc_d = featurebits[cart_pkg::FEAT_SRTC] & ~addr[22]
                & (addr[15:1] == 15'h1400);
  // $213f via the b-bus
  assign r213f_d = featurebits[cart_pkg::FEAT_213F] & ~addr[22] & (pa == 8'h3F);
  // b-bus f0-ff, command port read window
  assign cmd_rd_d = ~addr[22] & (&pa[7:4]);

  // a0 picks data vs status register
  always_comb begin
    case (mapper)
      cart_pkg::MAP_LOROM: a0_d = addr[14];
      cart_pkg::MAP_HIROM: a0_d = addr[12];
      default:             a0_d = 1'b1;
    endcase
  end

  // address based hits only, for region priority
  assign periph_hit = msu_d | srtc_d | dspx_hit;

  // held until the next request
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      msu_en        <= 1'b0;
      srtc_en       <= 1'b0;
      dspx_en       <= 1'b0;
      dspx_a0       <= 1'b1;
      r213f_en      <= 1'b0;
      snescmd_rd_en <= 1'b0;
    end else if (req) begin
      msu_en        <= msu_d;
      srtc_en       <= srtc_d;
      dspx_en       <= dspx_hit;
      dspx_a0       <= a0_d;
      r213f_en      <= r213f_d;
      snescmd_rd_en <= cmd_rd_d;
    end
  end

endmodule

//--- rtl/address_map.sv
module address_map (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              req,
  input  logic [23:0]       addr,
  input  cart_pkg::mapper_e mapper,
  input  logic [7:0]        featurebits,
  input  logic [23:0]       rom_mask,
  input  logic [23:0]       saveram_mask,
  input  logic              periph_hit,
  map_if.mapper             map
);

  logic              hi_save;
  logic              lo_save;
  logic              is_saveram;
  logic              is_rom;
  logic              cmd_hit;
  logic              dspx_range;
  logic [14:0]       menu_off;
  logic [23:0]       save_addr;
  logic [23:0]       menu_save_addr;
  logic [23:0]       rom_addr;
  logic [23:0]       xlat_addr;
  cart_pkg::region_e region_d;

  //////////////////////////////////////////////////////////////////////
  // classification
  //////////////////////////////////////////////////////////////////////

  // hirom style save RAM, banks 20-3f / a0-bf at 6000-7fff
  assign hi_save = ~addr[22] & addr[21] & (&addr[14:13]) & ~addr[15];
  // lorom save RAM, banks 70-7d / f0-fd below 8000
  assign lo_save = (&addr[22:20]) & (addr[19:16] < 4'hE) & ~addr[15];

  // no save RAM at all unless mask bit 0 is set
  always_comb begin
    case (mapper)
      cart_pkg::MAP_HIROM,
      cart_pkg::MAP_EXHIROM,
      cart_pkg::MAP_MENU:  is_saveram = saveram_mask[0] & hi_save;
      cart_pkg::MAP_LOROM: is_saveram = saveram_mask[0] & lo_save;
      default:             is_saveram = 1'b0;
    endcase
  end

  // upper banks or upper half of any bank
  assign is_rom  = addr[22] | addr[15];
  assign cmd_hit = (addr[23:4] == cart_pkg::CMD_WINDOW);

  // priority: command window, peripherals, save RAM, ROM
  always_comb begin
    if (cmd_hit) begin
      region_d = cart_pkg::REG_CMD;
    end else if (periph_hit) begin
      region_d = cart_pkg::REG_PERIPH;
    end else if (is_saveram) begin
      region_d = cart_pkg::REG_SAVERAM;
    end else if (is_rom) begin
      region_d = cart_pkg::REG_ROM;
    end else begin
      region_d = cart_pkg::REG_NONE;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // address translation
  //////////////////////////////////////////////////////////////////////

  // bank bits 20-16 over the 32k offset
  assign save_addr = cart_pkg::SAVERAM_BASE
                   + ({4'h0, addr[20:16], addr[14:0]} & saveram_mask);
  // menu save area starts at offset 6000
  assign menu_off       = addr[14:0] - 15'h6000;
  assign menu_save_addr = cart_pkg::MENU_SAVE_BASE
                        + ({9'h0, menu_off} & saveram_mask);

  always_comb begin
    case (mapper)
      cart_pkg::MAP_HIROM:   rom_addr = {1'b0, addr[22:0]} & rom_mask;
      // lorom drops offset bit 15
      cart_pkg::MAP_LOROM:   rom_addr = {2'b00, addr[22:16], addr[14:0]} & rom_mask;
      // banks 40-7d follow c0-ff
      cart_pkg::MAP_EXHIROM: rom_addr = {1'b0, ~addr[23], addr[21:0]} & rom_mask;
      cart_pkg::MAP_MENU:    rom_addr = cart_pkg::MENU_ROM_BASE
                                      + ({1'b0, addr[22:0]} & rom_mask);
      default:               rom_addr = 24'h0;
    endcase
  end

  always_comb begin
    case (region_d)
      // buffer index rides in the low nibble
      cart_pkg::REG_CMD:     xlat_addr = {20'h0, addr[3:0]};
      cart_pkg::REG_SAVERAM: xlat_addr = (mapper == cart_pkg::MAP_MENU) ?
                                         menu_save_addr : save_addr;
      default:               xlat_addr = rom_addr;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // DSP-x window
  //////////////////////////////////////////////////////////////////////

  // lorom: 30-3f upper half, or 60-6f lower half on large images
  // hirom: 00-0f at 6000-7fff
  always_comb begin
    case (mapper)
      cart_pkg::MAP_LOROM: dspx_range = rom_mask[20] ?
                                        (addr[22:20] == 3'b110) & ~addr[15] :
                                        (addr[22:20] == 3'b011) & addr[15];
      cart_pkg::MAP_HIROM: dspx_range = (addr[22:20] == 3'b000) & ~addr[15]
                                      & (&addr[14:13]);
      default:             dspx_range = 1'b0;
    endcase
  end

  assign map.dspx_hit = featurebits[cart_pkg::FEAT_DSPX] & dspx_range;

  // result registers
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      map.region   <= cart_pkg::REG_NONE;
      map.writable <= 1'b0;
      map.valid    <= 1'b0;
    end else begin
      map.valid <= req;
      if (req) begin
        map.region   <= region_d;
        map.writable <= (region_d == cart_pkg::REG_SAVERAM);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      map.sram_addr <= xlat_addr;
    end
  end

  a_no_saveram_when_absent: assert property (
    @(posedge clk) disable iff (!arst_n)
    req && !saveram_mask[0] |=> map.region != cart_pkg::REG_SAVERAM
  );

endmodule

//--- rtl/map_if.sv
interface map_if;

  // decode class, registered at the request edge
  cart_pkg::region_e region;
  // translated SRAM address, or command buffer index in its low nibble
  logic [23:0]       sram_addr;
  // only save RAM takes writes
  logic              writable;
  // combinational DSP-x range hit for the enable decoder
  logic              dspx_hit;
  // one cycle after the request, result is fresh
  logic              valid;

  modport mapper (
    output region, sram_addr, writable, dspx_hit, valid
  );

  modport ctrl (
    input region, sram_addr, writable, dspx_hit, valid
  );

endinterface

//--- rtl/cart_pkg.sv
package cart_pkg;

  //////////////////////////////////////////////////////////////////////
  // enumerations
  //////////////////////////////////////////////////////////////////////

  // mapper index as reported by the MCU
  typedef enum logic [2:0] {
    MAP_HIROM   = 3'd0,
    MAP_LOROM   = 3'd1,
    MAP_EXHIROM = 3'd2,
    MAP_MENU    = 3'd7
  } mapper_e;

  // decode class of one console access
  typedef enum logic [2:0] {
    REG_NONE,
    REG_ROM,
    REG_SAVERAM,
    REG_PERIPH,
    REG_CMD
  } region_e;

  // bus controller states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DECODE,
    ST_BUS,
    ST_ACK
  } ctrl_state_e;

  //////////////////////////////////////////////////////////////////////
  // feature word and memory layout
  //////////////////////////////////////////////////////////////////////

  // bit positions in featurebits
  localparam int FEAT_DSPX = 0;
  localparam int FEAT_SRTC = 2;
  localparam int FEAT_MSU1 = 3;
  localparam int FEAT_213F = 4;

  // save RAM sits at the top of the external SRAM
  localparam logic [23:0] SAVERAM_BASE   = 24'hE00000;
  // menu image layout
  localparam logic [23:0] MENU_SAVE_BASE = 24'hFF0000;
  localparam logic [23:0] MENU_ROM_BASE  = 24'hC00000;
  // command window, matched against addr[23:4]
  localparam logic [19:0] CMD_WINDOW     = 20'hCCCCC;
  // value seen on the console bus when nobody drives it
  localparam logic [7:0]  OPEN_BUS       = 8'hFF;

endpackage
